/* common/neopixel_cfg.svh */
`ifndef NEOPIXEL_CFG_SVH
`define NEOPIXEL_CFG_SVH

// highest index of the pixel buffer, so the buffer holds 16 pixels
`define NEOPIXEL_BUFFER_END 15
`define NEOPIXEL_BUFFER_BITS 4 // bits needed to address every buffer entry

// low gap after the last pixel, 350 cycles of 7 MHz is about 50 us
`define NEOPIXEL_RESET_CYCLES 350

// high time of one data bit in 7 MHz sub-steps out of 8
`define NEOPIXEL_T0H 2 // a zero bit is a short pulse
`define NEOPIXEL_T1H 5 // a one bit is a long pulse

`endif

/* common/neopixel_pkg.sv */
`include "neopixel_cfg.svh"

package neopixel_pkg;

  // one pixel in GRB order, the MSB goes out first
  typedef logic [23:0] pixel_t;

  // address into the pixel buffer
  typedef logic [`NEOPIXEL_BUFFER_BITS-1:0] pixel_index_t;

  // line state as seen by the sequencer
  typedef enum logic [1:0] {
    IDLE     = 2'd0, // line held low and nothing is counted
    TRANSMIT = 2'd1, // pixels are being shifted out
    RESET    = 2'd2  // low gap that latches the frame in the LEDs
  } neopixel_state_e;

  // control levels set by the host
  typedef struct packed {
    logic init;   // holds the engine and rewinds the counters
    logic run;    // lets frames repeat for as long as it stays high
    logic limit;  // ends the frame at reg_max instead of the buffer end
    logic mode32; // sends every fourth entry only
  } neopixel_ctrl_t;

  // where the stream is, handed from the stream controller to the encoder
  typedef struct packed {
    logic       active;            // a bit is on the line this cycle
    logic [2:0] bit_pattern_index; // sub-step inside the bit, counts 0 to 7
    logic [4:0] pixel_bit_index;   // bit inside the pixel, counts 0 to 23
  } stream_pos_t;

endpackage

/* hdl/neopixel_sequencer.sv */
`timescale 1ns/1ns
`include "neopixel_cfg.svh"

module neopixel_sequencer (
  input  logic                          clk7mhz,
  input  logic                          rst_n,
  input  neopixel_pkg::neopixel_ctrl_t  ctrl,
  input  logic                          stream_pixel_of, // last bit of the last pixel
  output neopixel_pkg::neopixel_state_e state
);

  import neopixel_pkg::*;

  // the gap counter only needs to reach NEOPIXEL_RESET_CYCLES-1
  logic [$clog2(`NEOPIXEL_RESET_CYCLES)-1:0] gap_cnt;
  logic gap_expired; // last cycle of the low gap
  logic enabled;     // host lets the line run

  assign enabled     = ctrl.run && !ctrl.init;
  assign gap_expired = (gap_cnt == `NEOPIXEL_RESET_CYCLES - 1);

  always_ff @(posedge clk7mhz) begin
    if (!rst_n) begin
      state <= IDLE;
    end else if (!enabled) begin
      state <= IDLE; // init high or run low wins over every state
    end else begin
      case (state)
        IDLE: begin
          state <= TRANSMIT; // start sending on the cycle after run rises
        end
        TRANSMIT: begin
          if (stream_pixel_of) state <= RESET; // frame is out, hold the line low
        end
        RESET: begin
          if (gap_expired) state <= TRANSMIT; // repeat the frame
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // counts the cycles spent in RESET and starts from zero on every entry
  always_ff @(posedge clk7mhz) begin
    if (!rst_n || state != RESET) gap_cnt <= '0;
    else gap_cnt <= gap_cnt + 1'b1;
  end

  // the low gap always lasts its full length before the next frame
  a_full_gap: assert property (@(posedge clk7mhz) disable iff (!rst_n)
    (state == TRANSMIT && $past(state) == RESET)
      |-> $past(state == RESET, `NEOPIXEL_RESET_CYCLES))
    else $error("sequencer left the reset gap early");

endmodule

/* stream/neopixel_stream_ctrl.sv */
`timescale 1ns/1ns
`include "neopixel_cfg.svh"

module neopixel_stream_ctrl (
  input  logic                          clk7mhz,
  input  logic                          rst_n,
  input  neopixel_pkg::neopixel_ctrl_t  ctrl,
  input  neopixel_pkg::neopixel_state_e state,
  input  logic [12:0]                   reg_max, // only the low index bits matter
  output neopixel_pkg::stream_pos_t     pos,
  output neopixel_pkg::pixel_index_t    pixel_index, // read address into the buffer
  output logic                          stream_pixel_of
);

  import neopixel_pkg::*;

  logic [2:0]   bit_pattern_index; // sub-step inside the current bit
  logic [4:0]   pixel_bit_index;   // bit inside the current pixel
  logic         stream_output;     // a bit is being sent this cycle
  logic         stream_pattern_of; // last sub-step of a bit
  logic         stream_bit_of;     // last sub-step of the last bit of a pixel
  logic         stream_pixel_last; // current pixel is the final one of the frame
  pixel_index_t pixel_index_max;   // final index of the frame
  pixel_index_t pixel_index_equiv; // index as compared against the limit

  assign stream_output     = ctrl.run && !ctrl.init && state == TRANSMIT;
  assign stream_pattern_of = stream_output && bit_pattern_index == 3'd7;
  assign stream_bit_of     = stream_pattern_of && pixel_bit_index == 5'd23;

  // with limit set the host picks the end, otherwise the whole buffer goes out
  assign pixel_index_max = ctrl.limit ? reg_max[`NEOPIXEL_BUFFER_BITS-1:0]
                                      : pixel_index_t'(`NEOPIXEL_BUFFER_END);

  // in 32-bit mode the index moves in steps of four, so the top of each
  // group of four is what meets the limit
  assign pixel_index_equiv = ctrl.mode32 ? {pixel_index[`NEOPIXEL_BUFFER_BITS-1:2], 2'b11}
                                         : pixel_index;

  assign stream_pixel_last = (pixel_index_equiv == pixel_index_max);
  assign stream_pixel_of   = stream_bit_of && stream_pixel_last;

  assign pos = '{active:            stream_output,
                 bit_pattern_index: bit_pattern_index,
                 pixel_bit_index:   pixel_bit_index};

  // eight sub-steps make one bit and the counter simply wraps
  always_ff @(posedge clk7mhz) begin
    if (!rst_n || ctrl.init) bit_pattern_index <= '0;
    else if (stream_output) bit_pattern_index <= bit_pattern_index + 3'd1;
  end

  always_ff @(posedge clk7mhz) begin
    if (!rst_n || ctrl.init) begin
      pixel_bit_index <= '0;
    end else if (stream_pattern_of) begin
      pixel_bit_index <= stream_bit_of ? 5'd0 : pixel_bit_index + 5'd1; // 24 bits a pixel
    end
  end

  always_ff @(posedge clk7mhz) begin
    if (!rst_n || ctrl.init) begin
      pixel_index <= '0; // next frame starts again at the first pixel
    end else if (stream_bit_of) begin
      if (stream_pixel_last) begin
        pixel_index <= '0; // frame ends here and the sequencer starts the gap
      end else begin
        pixel_index <= ctrl.mode32 ? pixel_index + 4'd4 : pixel_index + 4'd1;
      end
    end
  end

  a_bit_range: assert property (@(posedge clk7mhz) disable iff (!rst_n)
    pixel_bit_index <= 5'd23)
    else $error("pixel bit index ran past the last bit of a pixel");

endmodule

/* hdl/neopixel_pixel_buffer.sv */
`timescale 1ns/1ns
`include "neopixel_cfg.svh"

module neopixel_pixel_buffer (
  input  logic                       clk7mhz,
  input  logic                       wr_en,   // one-cycle write strobe from the host
  input  neopixel_pkg::pixel_index_t wr_addr,
  input  neopixel_pkg::pixel_t       wr_data,
  input  neopixel_pkg::pixel_index_t rd_addr, // follows the stream position
  output neopixel_pkg::pixel_t       rd_data  // valid one cycle after rd_addr
);

  import neopixel_pkg::*;

  // one entry per pixel of the chain
  pixel_t mem [0:`NEOPIXEL_BUFFER_END];

  // host writes land on the clock edge and are seen by the next read of that entry
  always_ff @(posedge clk7mhz) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // registered read port
  // the encoder delays the stream position by one cycle to match this stage
  always_ff @(posedge clk7mhz) begin
    rd_data <= mem[rd_addr];
  end

  // a write and a read of the same entry in the same cycle returns the old
  // pixel, which only matters if the host writes during transmit

  // the read address only changes on a pixel boundary, so one pixel stays
  // on rd_data for all 192 cycles it is on the line

  // 32-bit mode skips entries through the index step and not through
  // the address mapping here, so the buffer stays a plain memory

  // since there is no handshake the host may write at any time and the
  // line keeps running from whatever the memory holds

  // sized to fit a block of distributed RAM in most FPGA families
  // with a single clock domain for both ports

endmodule

/* hdl/neopixel_bit_encoder.sv */
`timescale 1ns/1ns
`include "neopixel_cfg.svh"

module neopixel_bit_encoder (
  input  logic                      clk7mhz,
  input  logic                      rst_n,
  input  neopixel_pkg::stream_pos_t pos,      // stream position from the controller
  input  neopixel_pkg::pixel_t      pixel,    // buffer read data, one cycle late
  input  logic                      pixel_of, // last sub-step of the frame
  output logic                      dout,     // serial line to the LED chain
  output logic                      frame_done
);

  import neopixel_pkg::*;

  stream_pos_t pos_q;      // position lined up with the buffer read data
  logic        pixel_of_q;
  logic [4:0]  bit_sel;    // pixel bit on the line, MSB first
  logic        bit_value;
  logic [2:0]  high_steps; // sub-steps the line stays high for this bit

  // one stage so the position matches the registered buffer read
  always_ff @(posedge clk7mhz) begin
    if (!rst_n) begin
      pos_q      <= '0;
      pixel_of_q <= 1'b0;
    end else begin
      pos_q      <= pos;
      pixel_of_q <= pixel_of;
    end
  end

  assign bit_sel    = 5'd23 - pos_q.pixel_bit_index; // bit 23 of GRB goes out first
  assign bit_value  = pixel[bit_sel];
  assign high_steps = bit_value ? 3'(`NEOPIXEL_T1H) : 3'(`NEOPIXEL_T0H);

  // line is high at the start of each bit and low whenever nothing is sent
  always_ff @(posedge clk7mhz) begin
    if (!rst_n) begin
      dout       <= 1'b0;
      frame_done <= 1'b0;
    end else begin
      dout       <= pos_q.active && (pos_q.bit_pattern_index < high_steps);
      frame_done <= pixel_of_q; // lags the frame end by the same two cycles as dout
    end
  end

  // every frame ends with one sub-step of the low tail of its last bit
  a_done_low: assert property (@(posedge clk7mhz) disable iff (!rst_n)
    frame_done |-> !dout)
    else $error("frame done pulse while the line is high");

endmodule

/* hdl/neopixel_top.sv */
`timescale 1ns/1ns

module neopixel_top (
  input  logic                         clk7mhz,
  input  logic                         rst_n,
  input  neopixel_pkg::neopixel_ctrl_t ctrl,    // host control levels
  input  logic [12:0]                  reg_max, // software frame limit
  input  logic                         wr_en,
  input  neopixel_pkg::pixel_index_t   wr_addr,
  input  neopixel_pkg::pixel_t         wr_data,
  output logic                         dout,    // serial line to the LEDs
  output logic                         frame_done
);

  import neopixel_pkg::*;

  neopixel_state_e state;           // sequencer state seen by the stream controller
  logic            stream_pixel_of; // end of frame from the stream controller
  pixel_index_t    pixel_index;     // buffer read address
  stream_pos_t     pos;             // stream position for the encoder
  pixel_t          rd_data;         // pixel currently being shifted out

  // decides when the line sends, rests in the gap or sits idle
  neopixel_sequencer neopixel_sequencer_i (
    .clk7mhz         (clk7mhz),
    .rst_n           (rst_n),
    .ctrl            (ctrl),
    .stream_pixel_of (stream_pixel_of),
    .state           (state)
  );

  // producer side, walks sub-steps, bits and pixels
  neopixel_stream_ctrl neopixel_stream_ctrl_i (
    .clk7mhz         (clk7mhz),
    .rst_n           (rst_n),
    .ctrl            (ctrl),
    .state           (state),
    .reg_max         (reg_max),
    .pos             (pos),
    .pixel_index     (pixel_index),
    .stream_pixel_of (stream_pixel_of)
  );

  neopixel_pixel_buffer neopixel_pixel_buffer_i (
    .clk7mhz (clk7mhz),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_addr (pixel_index),
    .rd_data (rd_data)
  );

  // consumer side, turns each bit into a short or long pulse
  neopixel_bit_encoder neopixel_bit_encoder_i (
    .clk7mhz    (clk7mhz),
    .rst_n      (rst_n),
    .pos        (pos),
    .pixel      (rd_data),
    .pixel_of   (stream_pixel_of),
    .dout       (dout),
    .frame_done (frame_done)
  );

endmodule

/* verif/neopixel_tb.sv */
`timescale 1ns/1ns
`include "neopixel_cfg.svh"

module neopixel_tb;

  import neopixel_pkg::*;

  typedef pixel_t pixel_list_t[$];

  // frames sent over the run, with the init test counted as two frames of four
  localparam int FRAME_PIXELS    = 4 + 3 + 2 * 4 + 16 + 2 * 4;
  localparam int FRAME_COUNT     = 7;
  localparam int WATCHDOG_CYCLES = FRAME_PIXELS * 192 + FRAME_COUNT * `NEOPIXEL_RESET_CYCLES
                                   + 3000;

  logic           clk7mhz = 1'b0;
  logic           rst_n;
  neopixel_ctrl_t ctrl;
  logic [12:0]    reg_max;
  logic           wr_en;
  pixel_index_t   wr_addr;
  pixel_t         wr_data;
  logic           dout;
  logic           frame_done;

  pixel_t      model [0:`NEOPIXEL_BUFFER_END]; // what the host has written so far
  pixel_list_t expected_q;                     // pixels still due on the line
  pixel_list_t one_frame;
  integer      seed = 32'h3872;
  int          errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  string       test_name = "reset";
  logic        decode_hold = 1'b1; // decoder drops partial bits while set
  int          high_cnt = 0;
  int          bit_cnt = 0;
  pixel_t      shift = '0;
  pixel_t      exp_pix;

  always #50 clk7mhz = ~clk7mhz; // 100 ns period

  neopixel_top neopixel_top_i (
    .clk7mhz    (clk7mhz),
    .rst_n      (rst_n),
    .ctrl       (ctrl),
    .reg_max    (reg_max),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .dout       (dout),
    .frame_done (frame_done)
  );

  // expected pixels of one frame, walking the buffer model from entry 0
  function automatic pixel_list_t expected_frame(input logic limit, input logic [12:0] max_idx,
                                                 input logic mode32);
    pixel_list_t list;
    int          last_idx;
    int          step;
    last_idx = limit ? int'(max_idx[`NEOPIXEL_BUFFER_BITS-1:0]) : `NEOPIXEL_BUFFER_END;
    step     = mode32 ? 4 : 1; // one pixel per 32-bit word skips three entries
    for (int n = 0; n <= last_idx; n += step) begin
      list.push_back(model[n]); // every entry the step lands on up to the last index
    end
    return list;
  endfunction

  // pulse widths on dout become bits, 24 bits become a pixel that is checked at once
  always @(negedge clk7mhz) begin
    if (decode_hold) begin
      high_cnt = 0;
      bit_cnt  = 0;
      shift    = '0;
    end else if (dout) begin
      high_cnt = high_cnt + 1;
    end else if (high_cnt != 0) begin
      if (high_cnt == `NEOPIXEL_T1H || high_cnt == `NEOPIXEL_T0H) begin
        shift   = {shift[22:0], high_cnt == `NEOPIXEL_T1H}; // MSB arrives first
        bit_cnt = bit_cnt + 1;
      end else begin
        $display("%s: bad pulse of %0d cycles on dout", test_name, high_cnt);
        errors++;
      end
      high_cnt = 0;
      if (bit_cnt == 24) begin
        bit_cnt = 0;
        if (expected_q.size() == 0) begin
          $display("%s: pixel %06h arrived after the frame should have ended", test_name, shift);
          errors++;
        end else begin
          exp_pix = expected_q.pop_front();
          if (shift !== exp_pix) begin
            $display("MISMATCH %s: expected %06h actual %06h", test_name, exp_pix, shift);
            errors++;
          end
        end
      end
    end
  end

  task automatic set_ctrl(input logic init, input logic run, input logic limit,
                          input logic mode32, input logic [12:0] max_idx);
    @(posedge clk7mhz);
    ctrl    <= '{init: init, run: run, limit: limit, mode32: mode32};
    reg_max <= max_idx;
  endtask

  task automatic write_pixel(input pixel_index_t addr, input pixel_t value);
    @(posedge clk7mhz);
    wr_en   <= 1'b1;
    wr_addr <= addr;
    wr_data <= value;
    @(posedge clk7mhz);
    wr_en   <= 1'b0;
    model[addr] = value; // the write has landed by now
  endtask

  // frame_done must rise within the limit and drop again on the next cycle
  task automatic wait_frame_done(input int max_cycles);
    int waited;
    waited = 0;
    @(negedge clk7mhz);
    while (frame_done !== 1'b1 && waited < max_cycles) begin
      @(negedge clk7mhz);
      waited++;
    end
    if (frame_done !== 1'b1) begin
      $display("%s: no frame_done pulse within %0d cycles", test_name, max_cycles);
      errors++;
    end else begin
      @(negedge clk7mhz);
      if (frame_done !== 1'b0) begin
        $display("%s: frame_done stayed high for more than one cycle", test_name);
        errors++;
      end
    end
  endtask

  task automatic check_frame_end();
    if (expected_q.size() != 0) begin
      $display("%s: frame ended with %0d pixels never sent", test_name, expected_q.size());
      errors++;
    end
  endtask

  // counts low cycles from the frame end until the next frame raises dout
  task automatic measure_gap();
    int low;
    low = 0;
    while (dout === 1'b0 && low < 2 * `NEOPIXEL_RESET_CYCLES) begin
      @(negedge clk7mhz);
      low++;
    end
    if (dout !== 1'b1) begin
      $display("%s: second frame never started after the gap", test_name);
      errors++;
    end else if (low < `NEOPIXEL_RESET_CYCLES) begin
      $display("%s: reset gap of only %0d low cycles", test_name, low);
      errors++;
    end
  endtask

  task automatic stop_line();
    set_ctrl(1'b0, 1'b0, 1'b0, 1'b0, 13'd0);
    repeat (4) @(posedge clk7mhz); // engine drops back to IDLE
  endtask

  task automatic finish_test(input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("test %s: ok", test_name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", test_name, errors - errors_before);
    end
  endtask

  // line must stay quiet for the whole gap after reset
  task automatic run_reset_test();
    int e0;
    e0 = errors;
    repeat (50) begin
      @(negedge clk7mhz);
      if (dout !== 1'b0 || frame_done !== 1'b0) begin
        $display("%s: dout or frame_done went high with run low", test_name);
        errors++;
      end
    end
    finish_test(e0);
  endtask

  // one frame with the given settings, checked pixel by pixel by the decoder
  task automatic run_frame_test(input string name, input logic limit, input logic [12:0] max_idx,
                                input logic mode32, input int pixels);
    int e0;
    test_name  = name;
    e0         = errors;
    expected_q = expected_frame(limit, max_idx, mode32);
    set_ctrl(1'b0, 1'b1, limit, mode32, max_idx);
    wait_frame_done(pixels * 192 + 100);
    check_frame_end();
    stop_line();
    finish_test(e0);
  endtask

  initial begin
    int e0;
    rst_n   = 1'b0;
    ctrl    = '0;
    reg_max = '0;
    wr_en   = 1'b0;
    wr_addr = '0;
    wr_data = '0;
    repeat (8) @(posedge clk7mhz);
    rst_n <= 1'b1;

    run_reset_test();

    for (int i = 0; i <= `NEOPIXEL_BUFFER_END; i++) begin
      write_pixel(pixel_index_t'(i), pixel_t'($random(seed)));
    end
    decode_hold = 1'b0;

    run_frame_test("limit_8bit", 1'b1, 13'd3, 1'b0, 4);
    run_frame_test("limit_32bit", 1'b1, 13'd11, 1'b1, 3);

    // two frames in a row, both compared against the same list
    test_name  = "gap_repeat";
    e0         = errors;
    one_frame  = expected_frame(1'b1, 13'd3, 1'b0);
    expected_q = one_frame;
    foreach (one_frame[i]) expected_q.push_back(one_frame[i]);
    set_ctrl(1'b0, 1'b1, 1'b1, 1'b0, 13'd3);
    wait_frame_done(4 * 192 + 100);
    measure_gap();
    wait_frame_done(4 * 192 + 100);
    check_frame_end();
    stop_line();
    finish_test(e0);

    run_frame_test("no_limit", 1'b0, 13'd3, 1'b0, 16); // reg_max is ignored here

    // init mid-frame, then pixel 0 is rewritten while the line is held
    test_name  = "init_rewrite";
    e0         = errors;
    expected_q = expected_frame(1'b1, 13'd3, 1'b0);
    set_ctrl(1'b0, 1'b1, 1'b1, 1'b0, 13'd3);
    repeat (300) @(negedge clk7mhz);
    while (dout !== 1'b1) @(negedge clk7mhz);
    while (dout !== 1'b0) @(negedge clk7mhz); // init lands in the low tail of a bit
    set_ctrl(1'b1, 1'b1, 1'b1, 1'b0, 13'd3);
    decode_hold = 1'b1;
    expected_q.delete();
    repeat (20) begin
      @(negedge clk7mhz);
      if (dout !== 1'b0) begin
        $display("%s: dout went high while init was held", test_name);
        errors++;
      end
    end
    write_pixel(pixel_index_t'(0), ~model[0]);
    decode_hold = 1'b0;
    expected_q  = expected_frame(1'b1, 13'd3, 1'b0);
    set_ctrl(1'b0, 1'b1, 1'b1, 1'b0, 13'd3);
    wait_frame_done(4 * 192 + 100);
    check_frame_end();
    stop_line();
    finish_test(e0);

    $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk7mhz);
    $display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

/* vlog.f */
+incdir+common
common/neopixel_pkg.sv
hdl/neopixel_sequencer.sv
stream/neopixel_stream_ctrl.sv
hdl/neopixel_pixel_buffer.sv
hdl/neopixel_bit_encoder.sv
hdl/neopixel_top.sv
verif/neopixel_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the NeoPixel testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -f vlog.f --top-module neopixel_tb \
  --Mdir "$OBJ" -o neopixel_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

"./$OBJ/neopixel_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "ALL CHECKS PASSED" "$LOG"; then
  echo "result: pass"
  exit 0
fi

echo "result: fail"
exit 1
